// File: verilog/fetch_pkg.sv
package fetch_pkg;

    // datapath and cache geometry
    localparam int XLEN            = 32;
    localparam int BLOCK_W         = 128;
    localparam int WORDS_PER_BLOCK = BLOCK_W / XLEN;
    localparam int OFFSET_W        = $clog2(BLOCK_W / 8);   // byte offset inside a block
    localparam int LINE_CNT        = 16;
    localparam int INDEX_W         = $clog2(LINE_CNT);      // pc bits 7:4
    localparam int TAG_W           = XLEN - INDEX_W - OFFSET_W;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

    // predictor table, indexed by pc bits 5:2
    localparam int BP_ENTRIES = 16;
    localparam int BP_INDEX_W = $clog2(BP_ENTRIES);
    localparam int BP_TAG_W   = XLEN - BP_INDEX_W - 2;

    // major opcodes seen by the predecoder
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_IMM    = 7'b0010011,
        OP_OTHER  = 7'b0000000
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_DATA,
        WRITE
    } refill_state_e;

endpackage

// File: verilog/pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       stall_i,
    input  logic                       miss_i,

    input  logic                       redirect_i,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,

    input  logic                       pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,

    output logic [fetch_pkg::XLEN-1:0] pc_o
);

    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;

    // redirect wins over everything, even a stall
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (stall_i || miss_i) begin
            pc_d = pc_q;                        // hold until the line is in
        end else if (pred_taken_i) begin
            pc_d = pred_target_i;
        end else begin
            pc_d = pc_q + XLEN'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // redirect and predicted targets come from outside this block
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00
    ) else $error("fetch pc lost word alignment: %h", pc_q);

endmodule

// File: verilog/icache.sv
`timescale 1ns/100ps

module icache (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic [fetch_pkg::XLEN-1:0]    pc_i,

    input  logic                          block_write_i,
    input  logic [fetch_pkg::BLOCK_W-1:0] block_i,

    output logic                          hit_o,
    output logic [fetch_pkg::XLEN-1:0]    word_o
);

    import fetch_pkg::*;

    // word 0 of a block sits in the low bits
    logic [WORDS_PER_BLOCK-1:0][XLEN-1:0] data_q [LINE_CNT];
    logic [TAG_W-1:0]                     tag_q  [LINE_CNT];
    logic [LINE_CNT-1:0]                  valid_q;

    logic [INDEX_W-1:0]  line_idx;
    logic [TAG_W-1:0]    pc_tag;
    logic [OFFSET_W-3:0] word_sel;

    assign line_idx = pc_i[OFFSET_W +: INDEX_W];
    assign pc_tag   = pc_i[XLEN-1 -: TAG_W];
    assign word_sel = pc_i[OFFSET_W-1:2];

    // lookup
    assign hit_o  = valid_q[line_idx] && (tag_q[line_idx] == pc_tag);
    assign word_o = data_q[line_idx][word_sel];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (block_write_i) begin
            valid_q[line_idx] <= 1'b1;
        end
    end

    // the refill writes into the line of the current pc
    always_ff @(posedge clk_i) begin
        if (block_write_i) begin
            data_q[line_idx] <= block_i;
            tag_q[line_idx]  <= pc_tag;
        end
    end

endmodule

// File: verilog/icache_refill.sv
`timescale 1ns/100ps

module icache_refill (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic [fetch_pkg::XLEN-1:0]    pc_i,
    input  logic                          hit_i,

    input  logic                          mem_ready_i,
    input  logic                          mem_valid_i,
    input  logic [fetch_pkg::BLOCK_W-1:0] mem_block_i,
    output logic                          mem_req_o,
    output logic                          mem_read_o,
    output logic [fetch_pkg::XLEN-1:0]    mem_addr_o,

    output logic [fetch_pkg::BLOCK_W-1:0] block_o,
    output logic                          block_write_o
);

    import fetch_pkg::*;

    fetch_pkg::refill_state_e state_q;
    fetch_pkg::refill_state_e state_d;

    logic [XLEN-1:0]    blk_addr;
    logic [XLEN-1:0]    req_addr_q;      // block that is in flight
    logic [BLOCK_W-1:0] block_q;

    assign blk_addr = {pc_i[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!hit_i) state_d = REQUEST;
            end
            REQUEST: begin
                if (hit_i) begin
                    state_d = IDLE;            // a redirect landed on a cached line
                end else if (mem_ready_i) begin
                    state_d = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (mem_valid_i) state_d = WRITE;
            end
            WRITE:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_req_o) req_addr_q <= blk_addr;
        if (state_q == WAIT_DATA && mem_valid_i) begin
            block_q <= mem_block_i;
        end
    end

    assign mem_req_o  = (state_q == REQUEST) && !hit_i && mem_ready_i;
    assign mem_read_o = mem_req_o;          // fetch only ever reads
    assign mem_addr_o = blk_addr;
    assign block_o    = block_q;

    // drop the block if a redirect moved the pc to another line meanwhile
    assign block_write_o = (state_q == WRITE) && (blk_addr == req_addr_q);

    // a request leaves REQUEST and waits for the block
    a_req_then_wait: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o |=> state_q == WAIT_DATA
    ) else $error("memory request not followed by WAIT_DATA");

    a_write_after_data: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        block_write_o |-> $past(state_q == WAIT_DATA && mem_valid_i)
    ) else $error("block write without a block captured in WAIT_DATA");

    // the refilled line is visible to the lookup right after the write
    a_write_then_hit: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        block_write_o |=> (hit_i || $changed(pc_i))
    ) else $error("no hit after block write at %h", req_addr_q);

endmodule

// File: verilog/branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic [fetch_pkg::XLEN-1:0] pc_i,
    input  logic [fetch_pkg::XLEN-1:0] word_i,
    input  logic                       hit_i,

    input  logic                       update_valid_i,
    input  logic                       update_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] update_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] update_target_i,

    output logic                       pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o
);

    import fetch_pkg::*;

    logic [1:0]          cnt_q    [BP_ENTRIES];
    logic [BP_TAG_W-1:0] tag_q    [BP_ENTRIES];
    logic [XLEN-1:0]     target_q [BP_ENTRIES];
    logic [BP_ENTRIES-1:0] valid_q;

    logic            upd_valid_q;
    logic            upd_taken_q;
    logic [XLEN-1:0] upd_pc_q;
    logic [XLEN-1:0] upd_target_q;

    opcode_e             opcode;
    logic [BP_INDEX_W-1:0] idx;
    logic [BP_INDEX_W-1:0] upd_idx;
    logic [BP_TAG_W-1:0]   upd_tag;
    logic [1:0]            cnt_next;

    // predecode
    always_comb begin
        case (word_i[6:0])
            OP_BRANCH: opcode = OP_BRANCH;
            OP_JAL:    opcode = OP_JAL;
            OP_JALR:   opcode = OP_JALR;
            OP_IMM:    opcode = OP_IMM;
            default:   opcode = OP_OTHER;
        endcase
    end

    assign idx     = pc_i[2 +: BP_INDEX_W];
    assign upd_idx = upd_pc_q[2 +: BP_INDEX_W];
    assign upd_tag = upd_pc_q[XLEN-1 -: BP_TAG_W];

    assign pred_taken_o = hit_i && (opcode == OP_BRANCH) && valid_q[idx]
                          && (tag_q[idx] == pc_i[XLEN-1 -: BP_TAG_W])
                          && cnt_q[idx][1];                 // 2 or 3
    assign pred_target_o = target_q[idx];

    // saturating step, aliases just keep stepping the shared counter
    always_comb begin
        if (upd_taken_q) begin
            cnt_next = (cnt_q[upd_idx] == 2'd3) ? 2'd3 : cnt_q[upd_idx] + 2'd1;
        end else begin
            cnt_next = (cnt_q[upd_idx] == 2'd0) ? 2'd0 : cnt_q[upd_idx] - 2'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            upd_valid_q <= 1'b0;
            valid_q     <= '0;
            for (int i = 0; i < BP_ENTRIES; i++) begin
                cnt_q[i] <= 2'd1;                           // weakly not taken
            end
        end else begin
            upd_valid_q <= update_valid_i;
            if (upd_valid_q) begin
                valid_q[upd_idx] <= 1'b1;
                cnt_q[upd_idx]   <= cnt_next;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        upd_taken_q  <= update_taken_i;
        upd_pc_q     <= update_pc_i;
        upd_target_q <= update_target_i;
        if (upd_valid_q) begin
            tag_q[upd_idx] <= upd_tag;
            if (upd_taken_q) target_q[upd_idx] <= upd_target_q;
        end
    end

    // counters saturate, they never wrap between 0 and 3
    for (genvar i = 0; i < BP_ENTRIES; i++) begin : g_cnt_chk
        a_no_wrap_up: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            cnt_q[i] == 2'd3 |=> cnt_q[i] != 2'd0
        ) else $error("counter %0d wrapped from 3", i);

        a_no_wrap_down: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            cnt_q[i] == 2'd0 |=> cnt_q[i] != 2'd3
        ) else $error("counter %0d wrapped from 0", i);
    end

endmodule

// File: verilog/fetch_out.sv
`timescale 1ns/100ps

module fetch_out (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       stall_i,
    input  logic                       hit_i,
    input  logic                       flush_i,

    input  logic [fetch_pkg::XLEN-1:0] pc_i,
    input  logic [fetch_pkg::XLEN-1:0] word_i,
    input  logic                       pred_i,

    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic [fetch_pkg::XLEN-1:0] instr_o,
    output logic                       pred_o
);

    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] instr_q;
    logic            pred_q;
    logic            take;

    assign take = !stall_i && hit_i && !flush_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_q <= NOP_INSTR;
            pred_q  <= 1'b0;
        end else if (flush_i || (!stall_i && !hit_i)) begin
            instr_q <= NOP_INSTR;               // bubble
            pred_q  <= 1'b0;
        end else if (take) begin
            instr_q <= word_i;
            pred_q  <= pred_i;
        end
    end

    // pc only matters next to a real instruction
    always_ff @(posedge clk_i) begin
        if (take) pc_q <= pc_i;
    end

    assign pc_o    = pc_q;
    assign instr_o = instr_q;
    assign pred_o  = pred_q;

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic                          stall_i,
    input  logic                          mispredict_i,
    input  logic                          jal_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]    jal_pc_i,

    input  logic                          update_valid_i,
    input  logic                          update_taken_i,
    input  logic [fetch_pkg::XLEN-1:0]    update_pc_i,
    input  logic [fetch_pkg::XLEN-1:0]    update_target_i,

    input  logic                          mem_ready_i,
    input  logic                          mem_valid_i,
    input  logic [fetch_pkg::BLOCK_W-1:0] mem_block_i,
    output logic                          mem_req_o,
    output logic                          mem_read_o,
    output logic [fetch_pkg::XLEN-1:0]    mem_addr_o,

    output logic [fetch_pkg::XLEN-1:0]    pc_o,
    output logic [fetch_pkg::XLEN-1:0]    instr_o,
    output logic                          pred_o
);

    import fetch_pkg::*;

    logic [XLEN-1:0]    fetch_pc;
    logic               hit;
    logic [XLEN-1:0]    word;
    logic               block_write;
    logic [BLOCK_W-1:0] block;
    logic               pred_taken;
    logic [XLEN-1:0]    pred_target;
    logic               redirect;
    logic [XLEN-1:0]    redirect_pc;

    assign redirect    = mispredict_i | jal_valid_i;
    assign redirect_pc = mispredict_i ? update_target_i : jal_pc_i;

    pc_gen u_pc_gen (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .stall_i(stall_i), .miss_i(!hit),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .pred_taken_i(pred_taken), .pred_target_i(pred_target),
        .pc_o(fetch_pc)
    );

    icache u_icache (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .pc_i(fetch_pc),
        .block_write_i(block_write), .block_i(block),
        .hit_o(hit), .word_o(word)
    );

    icache_refill u_icache_refill (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .pc_i(fetch_pc), .hit_i(hit),
        .mem_ready_i(mem_ready_i), .mem_valid_i(mem_valid_i), .mem_block_i(mem_block_i),
        .mem_req_o(mem_req_o), .mem_read_o(mem_read_o), .mem_addr_o(mem_addr_o),
        .block_o(block), .block_write_o(block_write)
    );

    branch_predictor u_branch_predictor (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .pc_i(fetch_pc), .word_i(word), .hit_i(hit),
        .update_valid_i(update_valid_i), .update_taken_i(update_taken_i),
        .update_pc_i(update_pc_i), .update_target_i(update_target_i),
        .pred_taken_o(pred_taken), .pred_target_o(pred_target)
    );

    fetch_out u_fetch_out (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .stall_i(stall_i), .hit_i(hit), .flush_i(redirect),
        .pc_i(fetch_pc), .word_i(word), .pred_i(pred_taken),
        .pc_o(pc_o), .instr_o(instr_o), .pred_o(pred_o)
    );

endmodule

// File: tb/main_mem_model.sv
`timescale 1ns/100ps

module main_mem_model (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic                          req_i,
    input  logic [fetch_pkg::XLEN-1:0]    addr_i,

    output logic                          ready_o,
    output logic                          valid_o,
    output logic [fetch_pkg::BLOCK_W-1:0] block_o
);

    import fetch_pkg::*;

    logic [31:0]     lfsr_q;
    logic [31:0]     lfsr_1;
    logic [31:0]     lfsr_2;
    logic            busy_q;
    logic [2:0]      wait_q;
    logic [XLEN-1:0] addr_q;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // program image, branch at word 7 of every 64-byte chunk
    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] addr);
        if (addr[5:2] == 4'd7) begin
            return {17'b0, 3'b001, addr[10:6], 7'b1100011};
        end
        return {2'b01, addr[11:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [BLOCK_W-1:0] build_block(input logic [XLEN-1:0] base);
        logic [BLOCK_W-1:0] blk;
        blk = '0;
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            blk[i*XLEN +: XLEN] = word_at(base + XLEN'(4 * i));   // word 0 low
        end
        return blk;
    endfunction

    assign lfsr_1  = lfsr_step(lfsr_q);
    assign lfsr_2  = lfsr_step(lfsr_1);
    assign ready_o = !busy_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lfsr_q  <= 32'h845c;
            busy_q  <= 1'b0;
            wait_q  <= '0;
            addr_q  <= '0;
            valid_o <= 1'b0;
            block_o <= '0;
        end else begin
            valid_o <= 1'b0;
            if (!busy_q && req_i) begin
                busy_q <= 1'b1;
                addr_q <= addr_i;
                wait_q <= 3'd1 + {1'b0, lfsr_2[0], lfsr_1[0]};    // 1 to 4 cycles
                lfsr_q <= lfsr_2;
            end else if (busy_q) begin
                if (wait_q == 3'd1) begin
                    valid_o <= 1'b1;
                    block_o <= build_block(addr_q);
                    busy_q  <= 1'b0;
                end else begin
                    wait_q <= wait_q - 3'd1;
                end
            end
        end
    end

endmodule

// File: tb/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

    import fetch_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;

    logic               clk_i;
    logic               rst_n_i;
    logic               stall_i;
    logic               mispredict_i;
    logic               jal_valid_i;
    logic [XLEN-1:0]    jal_pc_i;
    logic               update_valid_i;
    logic               update_taken_i;
    logic [XLEN-1:0]    update_pc_i;
    logic [XLEN-1:0]    update_target_i;
    logic               mem_ready;
    logic               mem_valid;
    logic [BLOCK_W-1:0] mem_block;
    logic               mem_req_o;
    logic               mem_read_o;
    logic [XLEN-1:0]    mem_addr_o;
    logic [XLEN-1:0]    pc_o;
    logic [XLEN-1:0]    instr_o;
    logic               pred_o;

    // expected state of the output stream
    logic [XLEN-1:0] exp_pc;
    logic            nop_due;
    logic            req_pending;
    logic [XLEN-1:0] req_addr;
    logic            prev_stall;
    logic [XLEN-1:0] prev_pc;
    logic [XLEN-1:0] prev_instr;
    logic            prev_pred;
    int              out_count;
    int              pred_seen;
    int              cycle_cnt;

    // one-entry model of the trained branch
    logic            bp_valid;
    logic [XLEN-1:0] bp_pc;
    logic [XLEN-1:0] bp_target;
    logic [1:0]      bp_cnt;

    fetch_stage dut (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .stall_i(stall_i), .mispredict_i(mispredict_i),
        .jal_valid_i(jal_valid_i), .jal_pc_i(jal_pc_i),
        .update_valid_i(update_valid_i), .update_taken_i(update_taken_i),
        .update_pc_i(update_pc_i), .update_target_i(update_target_i),
        .mem_ready_i(mem_ready), .mem_valid_i(mem_valid), .mem_block_i(mem_block),
        .mem_req_o(mem_req_o), .mem_read_o(mem_read_o), .mem_addr_o(mem_addr_o),
        .pc_o(pc_o), .instr_o(instr_o), .pred_o(pred_o)
    );

    main_mem_model u_mem (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .req_i(mem_req_o), .addr_i(mem_addr_o),
        .ready_o(mem_ready), .valid_o(mem_valid), .block_o(mem_block)
    );

    function automatic logic [XLEN-1:0] image_word(input logic [XLEN-1:0] addr);
        if (addr[5:2] == 4'd7) begin
            return {17'b0, 3'b001, addr[10:6], 7'b1100011};   // bne
        end
        return {2'b01, addr[11:2], 5'd0, 3'b000, 5'd1, 7'b0010011};  // addi x1
    endfunction

    function automatic logic pred_expected(input logic [XLEN-1:0] pc);
        return bp_valid && (pc == bp_pc) && bp_cnt[1];
    endfunction

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, fetch stopped making progress", cycle_cnt);
            $display("Test failures found");
            $fatal(1);
        end
    end

    // compare process samples mid-cycle
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (prev_stall) begin
                check_word("pc_o", pc_o, prev_pc);
                check_word("instr_o", instr_o, prev_instr);
                check_bit("pred_o", pred_o, prev_pred);
            end else if (nop_due) begin
                check_word("instr_o", instr_o, NOP_INSTR);
                check_bit("pred_o", pred_o, 1'b0);
                nop_due = 1'b0;
            end else if (instr_o !== NOP_INSTR) begin
                check_word("instr_o", instr_o, image_word(pc_o));
                check_word("pc_o", pc_o, exp_pc);
                if (req_pending) check_word("pc_o block", {pc_o[XLEN-1:4], 4'b0}, req_addr);
                req_pending = 1'b0;
                check_bit("pred_o", pred_o, pred_expected(pc_o));
                if (pred_o) pred_seen++;
                exp_pc = pred_o ? bp_target : pc_o + 32'd4;
                out_count++;
            end else begin
                check_bit("pred_o", pred_o, 1'b0);      // bubbles carry no prediction
            end
            if (mem_req_o) begin
                check_word("mem_addr_o", mem_addr_o, {mem_addr_o[XLEN-1:4], 4'b0});
                check_bit("mem_read_o", mem_read_o, 1'b1);
                req_addr    = mem_addr_o;
                req_pending = 1'b1;
            end else begin
                check_bit("mem_read_o", mem_read_o, 1'b0);
            end
            if (jal_valid_i || mispredict_i) begin      // bubble at the next edge
                nop_due     = 1'b1;
                exp_pc      = mispredict_i ? update_target_i : jal_pc_i;
                req_pending = 1'b0;
            end
            prev_stall = stall_i;
            prev_pc    = pc_o;
            prev_instr = instr_o;
            prev_pred  = pred_o;
        end
    end

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_outputs(input int n);
        int target;
        target = out_count + n;
        while (out_count < target) @(posedge clk_i);
        #1;
    endtask

    task automatic jump_to(input logic [XLEN-1:0] target);
        jal_valid_i = 1'b1;
        jal_pc_i    = target;
        step();
        jal_valid_i = 1'b0;
    endtask

    task automatic mispredict_to(input logic [XLEN-1:0] target);
        mispredict_i    = 1'b1;
        update_target_i = target;
        step();
        mispredict_i = 1'b0;
    endtask

    task automatic train_branch(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target,
                                input logic taken);
        update_valid_i  = 1'b1;
        update_taken_i  = taken;
        update_pc_i     = pc;
        update_target_i = target;
        bp_valid = 1'b1;
        bp_pc    = pc;
        if (taken) begin
            bp_target = target;
            if (bp_cnt != 2'd3) bp_cnt = bp_cnt + 2'd1;
        end else if (bp_cnt != 2'd0) begin
            bp_cnt = bp_cnt - 2'd1;
        end
        step();
        update_valid_i = 1'b0;
    endtask

    task automatic hold_stall(input int cycles);
        stall_i = 1'b1;
        repeat (cycles) step();
        stall_i = 1'b0;
    endtask

    initial begin
        rst_n_i         = 1'b0;
        stall_i         = 1'b0;
        mispredict_i    = 1'b0;
        jal_valid_i     = 1'b0;
        jal_pc_i        = '0;
        update_valid_i  = 1'b0;
        update_taken_i  = 1'b0;
        update_pc_i     = '0;
        update_target_i = '0;
        exp_pc      = RESET_PC;
        nop_due     = 1'b0;
        req_pending = 1'b0;
        req_addr    = '0;
        prev_stall  = 1'b0;
        out_count   = 0;
        pred_seen   = 0;
        cycle_cnt   = 0;
        bp_valid    = 1'b0;
        bp_pc       = '0;
        bp_target   = '0;
        bp_cnt      = 2'd1;

        repeat (4) @(posedge clk_i);
        #1;
        check_word("instr_o", instr_o, NOP_INSTR);
        check_bit("pred_o", pred_o, 1'b0);
        check_bit("mem_req_o", mem_req_o, 1'b0);
        check_bit("mem_read_o", mem_read_o, 1'b0);
        rst_n_i = 1'b1;

        wait_outputs(40);                   // cold misses from RESET_PC
        jump_to(32'h0000_0200);
        wait_outputs(20);

        jump_to(32'h0000_0400);
        repeat (2) step();
        hold_stall(12);                     // refill lands while frozen
        wait_outputs(20);

        mispredict_to(32'h0000_0100);
        wait_outputs(10);

        train_branch(32'h0000_025c, 32'h0000_0300, 1'b1);
        jump_to(32'h0000_0240);
        wait_outputs(20);
        train_branch(32'h0000_025c, 32'h0000_0300, 1'b0);
        jump_to(32'h0000_0240);
        wait_outputs(20);

        if (pred_seen == 1) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("predicted branch seen %0d times instead of once", pred_seen);
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

// File: flist.f
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/icache.sv
verilog/icache_refill.sv
verilog/branch_predictor.sv
verilog/fetch_out.sv
verilog/fetch_stage.sv
tb/main_mem_model.sv
tb/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f flist.f

./obj_dir/Vfetch_tb 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    exit 1
fi
